// File: Bender.yml
package:
  name: llc_core

sources:
  - hw/llc_cfg_pkg.sv
  - hw/llc_meta_pkg.sv
  - hw/llc_set_ram.sv
  - hw/llc_bufs.sv
  - hw/llc_lookup_way.sv
  - hw/llc_process_request.sv
  - hw/llc_core.sv
  - target: simulation
    files:
      - sim/llc_mem_model.sv
      - sim/tb_llc_core.sv

// File: hw/llc_bufs.sv
/* set buffer registers for tags, states and lines
   plus the per-set round-robin evict pointers */

`timescale 1ns/10ps

module llc_bufs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load_i,
    input  llc_cfg_pkg::tag_t        tags_i [llc_cfg_pkg::LLC_WAYS],
    input  llc_meta_pkg::llc_state_t states_i [llc_cfg_pkg::LLC_WAYS],
    input  llc_cfg_pkg::line_t       lines_i [llc_cfg_pkg::LLC_WAYS],
    input  logic                     adv_evict_i,
    input  llc_cfg_pkg::set_t        set_i,
    output llc_cfg_pkg::tag_t        tags_buf_o [llc_cfg_pkg::LLC_WAYS],
    output llc_meta_pkg::llc_state_t states_buf_o [llc_cfg_pkg::LLC_WAYS],
    output llc_cfg_pkg::line_t       lines_buf_o [llc_cfg_pkg::LLC_WAYS],
    output llc_cfg_pkg::way_t        evict_way_o
);

    llc_cfg_pkg::way_t evict_ptr [llc_cfg_pkg::LLC_SETS];

    llc_cfg_pkg::way_t evict_next;

    // hold the set that was just read until the next request
    always_ff @(posedge clk) begin
        if (load_i) begin
            tags_buf_o   <= tags_i;
            states_buf_o <= states_i;
            lines_buf_o  <= lines_i;
        end
    end

    // next pointer wraps at the last way
    always_comb begin
        if (evict_ptr[set_i] == llc_cfg_pkg::way_t'(llc_cfg_pkg::LLC_WAYS - 1)) begin
            evict_next = '0;
        end else begin
            evict_next = evict_ptr[set_i] + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_cfg_pkg::LLC_SETS; s++) begin
                evict_ptr[s] <= '0;
            end
        end else if (adv_evict_i) begin
            evict_ptr[set_i] <= evict_next;
        end
    end

    assign evict_way_o = evict_ptr[set_i];

endmodule

// File: hw/llc_cfg_pkg.sv
/* cache geometry localparams and address field types
   for sets, ways, tags and line data */

package llc_cfg_pkg;

    // geometry
    localparam int LLC_SETS = 16;
    localparam int LLC_WAYS = 4;

    // field widths
    localparam int ADDR_BITS = 12;
    localparam int SET_BITS  = 4;
    localparam int WAY_BITS  = 2;
    localparam int TAG_BITS  = ADDR_BITS - SET_BITS;
    localparam int WORD_BITS = 32;

    // line address, set index in the low bits and tag above it
    typedef logic [ADDR_BITS-1:0] line_addr_t;

    typedef logic [SET_BITS-1:0] set_t;

    typedef logic [TAG_BITS-1:0] tag_t;

    typedef logic [WAY_BITS-1:0] way_t;

    // one line holds a single word
    typedef logic [WORD_BITS-1:0] line_t;

endpackage

// File: hw/llc_core.sv
/* cache core top, wires the controller to the tag, state
   and line memories, the set buffers and the way lookup */

`timescale 1ns/10ps

module llc_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid_i,
    input  logic                    req_write_i,
    input  llc_cfg_pkg::line_addr_t req_addr_i,
    input  llc_cfg_pkg::line_t      req_data_i,
    output logic                    rsp_valid_o,
    output llc_cfg_pkg::line_t      rsp_data_o,
    output logic                    rsp_hit_o,
    output logic                    mem_req_valid_o,
    output logic                    mem_req_write_o,
    output llc_cfg_pkg::line_addr_t mem_req_addr_o,
    output llc_cfg_pkg::line_t      mem_req_data_o,
    input  logic                    mem_rsp_valid_i,
    input  llc_cfg_pkg::line_t      mem_rsp_data_i
);

    llc_cfg_pkg::set_t        rd_set;
    logic                     load;
    logic                     adv_evict;
    logic                     wr_en;
    llc_cfg_pkg::set_t        wr_set;
    llc_cfg_pkg::way_t        wr_way;
    llc_cfg_pkg::tag_t        wr_tag;
    llc_meta_pkg::llc_state_t wr_state;
    llc_cfg_pkg::line_t       wr_line;

    // set memory read data
    llc_cfg_pkg::tag_t        rd_tags [llc_cfg_pkg::LLC_WAYS];
    llc_meta_pkg::llc_state_t rd_states [llc_cfg_pkg::LLC_WAYS];
    llc_cfg_pkg::line_t       rd_lines [llc_cfg_pkg::LLC_WAYS];

    // buffered set
    llc_cfg_pkg::tag_t        tags_buf [llc_cfg_pkg::LLC_WAYS];
    llc_meta_pkg::llc_state_t states_buf [llc_cfg_pkg::LLC_WAYS];
    llc_cfg_pkg::line_t       lines_buf [llc_cfg_pkg::LLC_WAYS];
    llc_cfg_pkg::way_t        evict_way;

    logic                     hit;
    llc_cfg_pkg::way_t        hit_way;
    llc_cfg_pkg::way_t        victim_way;

    llc_process_request u_process_request (
        .clk, .rst,
        .req_valid_i, .req_write_i, .req_addr_i, .req_data_i,
        .mem_rsp_valid_i, .mem_rsp_data_i,
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
        .states_buf_i(states_buf), .tags_buf_i(tags_buf), .lines_buf_i(lines_buf),
        .rsp_valid_o, .rsp_data_o, .rsp_hit_o,
        .mem_req_valid_o, .mem_req_write_o, .mem_req_addr_o, .mem_req_data_o,
        .rd_set_o(rd_set), .load_o(load), .adv_evict_o(adv_evict),
        .wr_en_o(wr_en), .wr_set_o(wr_set), .wr_way_o(wr_way),
        .wr_tag_o(wr_tag), .wr_state_o(wr_state), .wr_line_o(wr_line)
    );

    llc_set_ram #(.entry_t(llc_cfg_pkg::tag_t)) u_tags_ram (
        .clk, .rst, .rd_set_i(rd_set), .wr_en_i(wr_en), .wr_set_i(wr_set),
        .wr_way_i(wr_way), .wr_entry_i(wr_tag), .rd_ways_o(rd_tags)
    );

    llc_set_ram #(.entry_t(llc_meta_pkg::llc_state_t)) u_states_ram (
        .clk, .rst, .rd_set_i(rd_set), .wr_en_i(wr_en), .wr_set_i(wr_set),
        .wr_way_i(wr_way), .wr_entry_i(wr_state), .rd_ways_o(rd_states)
    );

    llc_set_ram #(.entry_t(llc_cfg_pkg::line_t)) u_lines_ram (
        .clk, .rst, .rd_set_i(rd_set), .wr_en_i(wr_en), .wr_set_i(wr_set),
        .wr_way_i(wr_way), .wr_entry_i(wr_line), .rd_ways_o(rd_lines)
    );

    llc_bufs u_bufs (
        .clk, .rst, .load_i(load),
        .tags_i(rd_tags), .states_i(rd_states), .lines_i(rd_lines),
        .adv_evict_i(adv_evict), .set_i(rd_set),
        .tags_buf_o(tags_buf), .states_buf_o(states_buf), .lines_buf_o(lines_buf),
        .evict_way_o(evict_way)
    );

    // the controller keeps the tag of the request in flight on wr_tag_o
    llc_lookup_way u_lookup_way (
        .tag_i(wr_tag),
        .tags_buf_i(tags_buf), .states_buf_i(states_buf), .evict_way_i(evict_way),
        .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way)
    );

endmodule

// File: hw/llc_lookup_way.sv
/* tag compare and victim way selection over the buffered set */

`timescale 1ns/10ps

module llc_lookup_way (
    input  llc_cfg_pkg::tag_t        tag_i,
    input  llc_cfg_pkg::tag_t        tags_buf_i [llc_cfg_pkg::LLC_WAYS],
    input  llc_meta_pkg::llc_state_t states_buf_i [llc_cfg_pkg::LLC_WAYS],
    input  llc_cfg_pkg::way_t        evict_way_i,
    output logic                     hit_o,
    output llc_cfg_pkg::way_t        hit_way_o,
    output llc_cfg_pkg::way_t        victim_way_o
);

    always_comb begin
        hit_o        = 1'b0;
        hit_way_o    = '0;
        victim_way_o = evict_way_i;

        // downward scan, so the lowest matching way wins
        for (int w = llc_cfg_pkg::LLC_WAYS - 1; w >= 0; w--) begin
            if (states_buf_i[w] != llc_meta_pkg::INVALID && tags_buf_i[w] == tag_i) begin
                hit_o     = 1'b1;
                hit_way_o = llc_cfg_pkg::way_t'(w);
            end
            // a free way beats the round-robin pointer
            if (states_buf_i[w] == llc_meta_pkg::INVALID) begin
                victim_way_o = llc_cfg_pkg::way_t'(w);
            end
        end
    end

endmodule

// File: hw/llc_meta_pkg.sv
/* line state encoding and per-way metadata types */

package llc_meta_pkg;

    localparam int STATE_BITS = 2;

    // invalid must stay zero, memories clear to it on reset
    typedef enum logic [STATE_BITS-1:0] {
        INVALID = 2'd0,
        VALID   = 2'd1,
        DIRTY   = 2'd2
    } llc_state_t;

endpackage

// File: hw/llc_process_request.sv
/* request register and stage FSM driving lookup, write-back,
   fill, set update and the response strobe */

`timescale 1ns/10ps

module llc_process_request (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid_i,
    input  logic                     req_write_i,
    input  llc_cfg_pkg::line_addr_t  req_addr_i,
    input  llc_cfg_pkg::line_t       req_data_i,
    input  logic                     mem_rsp_valid_i,
    input  llc_cfg_pkg::line_t       mem_rsp_data_i,
    input  logic                     hit_i,
    input  llc_cfg_pkg::way_t        hit_way_i,
    input  llc_cfg_pkg::way_t        victim_way_i,
    input  llc_meta_pkg::llc_state_t states_buf_i [llc_cfg_pkg::LLC_WAYS],
    input  llc_cfg_pkg::tag_t        tags_buf_i [llc_cfg_pkg::LLC_WAYS],
    input  llc_cfg_pkg::line_t       lines_buf_i [llc_cfg_pkg::LLC_WAYS],
    output logic                     rsp_valid_o,
    output llc_cfg_pkg::line_t       rsp_data_o,
    output logic                     rsp_hit_o,
    output logic                     mem_req_valid_o,
    output logic                     mem_req_write_o,
    output llc_cfg_pkg::line_addr_t  mem_req_addr_o,
    output llc_cfg_pkg::line_t       mem_req_data_o,
    output llc_cfg_pkg::set_t        rd_set_o,
    output logic                     load_o,
    output logic                     adv_evict_o,
    output logic                     wr_en_o,
    output llc_cfg_pkg::set_t        wr_set_o,
    output llc_cfg_pkg::way_t        wr_way_o,
    output llc_cfg_pkg::tag_t        wr_tag_o,
    output llc_meta_pkg::llc_state_t wr_state_o,
    output llc_cfg_pkg::line_t       wr_line_o
);

    typedef enum logic [2:0] {
        IDLE, READ_MEM, LOOKUP, PROCESS, WRITE_BACK, FILL_REQ, FILL_WAIT, UPDATE
    } stage_t;

    stage_t state_q;
    stage_t state_d;

    logic                    req_write_q;
    llc_cfg_pkg::line_addr_t req_addr_q;
    llc_cfg_pkg::line_t      req_data_q;
    logic                    hit_q;
    llc_cfg_pkg::way_t       hit_way_q;
    llc_cfg_pkg::way_t       victim_way_q;
    llc_cfg_pkg::line_t      fill_q;

    llc_cfg_pkg::set_t        req_set;
    llc_cfg_pkg::tag_t        req_tag;
    llc_cfg_pkg::way_t        upd_way;
    llc_meta_pkg::llc_state_t victim_state;

    assign req_set      = req_addr_q[llc_cfg_pkg::SET_BITS-1:0];
    assign req_tag      = req_addr_q[llc_cfg_pkg::ADDR_BITS-1:llc_cfg_pkg::SET_BITS];
    assign upd_way      = hit_q ? hit_way_q : victim_way_q;
    assign victim_state = states_buf_i[victim_way_q];

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:       if (req_valid_i) state_d = READ_MEM;
            READ_MEM:   state_d = LOOKUP;
            LOOKUP:     state_d = PROCESS;
            PROCESS: begin
                if (hit_i) begin
                    state_d = UPDATE;
                end else if (states_buf_i[victim_way_i] == llc_meta_pkg::DIRTY) begin
                    state_d = WRITE_BACK;
                end else begin
                    // a write covers the whole line, nothing to fetch
                    state_d = req_write_q ? UPDATE : FILL_REQ;
                end
            end
            WRITE_BACK: state_d = req_write_q ? UPDATE : FILL_REQ;
            FILL_REQ:   state_d = FILL_WAIT;
            FILL_WAIT:  if (mem_rsp_valid_i) state_d = UPDATE;
            UPDATE:     state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q     <= IDLE;
            rsp_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            rsp_valid_o <= (state_q == UPDATE);
        end
    end

    // request, lookup result, fill word and response payload
    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_valid_i) begin
            req_write_q <= req_write_i;
            req_addr_q  <= req_addr_i;
            req_data_q  <= req_data_i;
        end
        if (state_q == PROCESS) begin
            hit_q        <= hit_i;
            hit_way_q    <= hit_way_i;
            victim_way_q <= victim_way_i;
        end
        if (state_q == FILL_WAIT && mem_rsp_valid_i) begin
            fill_q <= mem_rsp_data_i;
        end
        if (state_q == UPDATE) begin
            rsp_data_o <= wr_line_o;
            rsp_hit_o  <= hit_q;
        end
    end

    // update data for the chosen way
    always_comb begin
        if (req_write_q) begin
            wr_state_o = llc_meta_pkg::DIRTY;
            wr_line_o  = req_data_q;
        end else if (hit_q) begin
            wr_state_o = states_buf_i[hit_way_q];
            wr_line_o  = lines_buf_i[hit_way_q];
        end else begin
            wr_state_o = llc_meta_pkg::VALID;
            wr_line_o  = fill_q;
        end
    end

    assign wr_en_o  = (state_q == UPDATE);
    assign wr_set_o = req_set;
    assign wr_way_o = upd_way;
    assign wr_tag_o = req_tag;

    // pointer only moves when a valid line was replaced
    assign adv_evict_o = (state_q == UPDATE) && !hit_q &&
                         (victim_state != llc_meta_pkg::INVALID);

    assign rd_set_o = req_set;
    assign load_o   = (state_q == LOOKUP);

    // victim write-back uses the buffered tag and line
    assign mem_req_valid_o = (state_q == WRITE_BACK) || (state_q == FILL_REQ);
    assign mem_req_write_o = (state_q == WRITE_BACK);
    assign mem_req_addr_o  = (state_q == WRITE_BACK) ?
                             {tags_buf_i[victim_way_q], req_set} : req_addr_q;
    assign mem_req_data_o  = lines_buf_i[victim_way_q];

endmodule

// File: hw/llc_set_ram.sv
/* set-indexed way storage, reads a whole set per cycle
   and writes one way, payload type set by parameter */

`timescale 1ns/10ps

module llc_set_ram #(
    parameter type entry_t = logic [7:0]
) (
    input  logic              clk,
    input  logic              rst,
    input  llc_cfg_pkg::set_t rd_set_i,
    input  logic              wr_en_i,
    input  llc_cfg_pkg::set_t wr_set_i,
    input  llc_cfg_pkg::way_t wr_way_i,
    input  entry_t            wr_entry_i,
    output entry_t            rd_ways_o [llc_cfg_pkg::LLC_WAYS]
);

    entry_t mem [llc_cfg_pkg::LLC_SETS][llc_cfg_pkg::LLC_WAYS];

    // storage array, cleared so every line starts out invalid
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_cfg_pkg::LLC_SETS; s++) begin
                for (int w = 0; w < llc_cfg_pkg::LLC_WAYS; w++) begin
                    mem[s][w] <= entry_t'(0);
                end
            end
        end else if (wr_en_i) begin
            mem[wr_set_i][wr_way_i] <= wr_entry_i;
        end
    end

    // registered read of all ways, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rd_ways_o <= mem[rd_set_i];
    end

endmodule

// File: project.f
hw/llc_cfg_pkg.sv
hw/llc_meta_pkg.sv
hw/llc_set_ram.sv
hw/llc_bufs.sv
hw/llc_lookup_way.sv
hw/llc_process_request.sv
hw/llc_core.sv
sim/llc_mem_model.sv
sim/tb_llc_core.sv

// File: sim/llc_mem_model.sv
/* word memory model with random read delay, and a check of
   write-back data against the last word the requester wrote */

`timescale 1ns/10ps

module llc_mem_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid_i,
    input  logic                    req_write_i,
    input  llc_cfg_pkg::line_addr_t req_addr_i,
    input  llc_cfg_pkg::line_t      req_data_i,
    input  logic                    mem_req_valid_i,
    input  logic                    mem_req_write_i,
    input  llc_cfg_pkg::line_addr_t mem_req_addr_i,
    input  llc_cfg_pkg::line_t      mem_req_data_i,
    output logic                    mem_rsp_valid_o,
    output llc_cfg_pkg::line_t      mem_rsp_data_o,
    output logic                    wb_err_o
);

    localparam int          DEPTH     = 1 << llc_cfg_pkg::ADDR_BITS;
    localparam logic [31:0] SEED_MASK = 32'ha5a50000;

    llc_cfg_pkg::line_t      words [DEPTH];
    llc_cfg_pkg::line_t      shadow [DEPTH];
    logic                    shadow_vld [DEPTH];
    integer                  seed = 87;
    integer                  rnd;
    logic                    pending;
    int unsigned             delay;
    llc_cfg_pkg::line_addr_t rd_addr;

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int a = 0; a < DEPTH; a++) begin
                words[a]      <= 32'(a) ^ SEED_MASK;
                shadow_vld[a] <= 1'b0;
            end
            pending         <= 1'b0;
            delay           <= 0;
            mem_rsp_valid_o <= 1'b0;
            mem_rsp_data_o  <= '0;
            wb_err_o        <= 1'b0;
        end else begin
            mem_rsp_valid_o <= 1'b0;

            // last word the requester wrote, per address
            if (req_valid_i && req_write_i) begin
                shadow[req_addr_i]     <= req_data_i;
                shadow_vld[req_addr_i] <= 1'b1;
            end

            if (pending) begin
                if (delay == 1) begin
                    mem_rsp_valid_o <= 1'b1;
                    mem_rsp_data_o  <= words[rd_addr];
                    pending         <= 1'b0;
                end else begin
                    delay <= delay - 1;
                end
            end

            if (mem_req_valid_i && mem_req_write_i) begin
                assert (shadow_vld[mem_req_addr_i]) else begin
                    $display("write-back of address %h, which was never written",
                             mem_req_addr_i);
                    wb_err_o <= 1'b1;
                end
                if (shadow_vld[mem_req_addr_i]) begin
                    assert (mem_req_data_i === shadow[mem_req_addr_i]) else begin
                        $display("mismatch mem_req_data_o at address %h: got %h expected %h",
                                 mem_req_addr_i, mem_req_data_i, shadow[mem_req_addr_i]);
                        wb_err_o <= 1'b1;
                    end
                end
                words[mem_req_addr_i] <= mem_req_data_i;
            end else if (mem_req_valid_i) begin
                // answer after 1 to 8 cycles
                rnd = $random(seed);
                pending <= 1'b1;
                delay   <= 1 + (rnd & 7);
                rd_addr <= mem_req_addr_i;
            end
        end
    end

endmodule

// File: sim/llc_testdata.hex
// op (0 read, 1 write, f end), address, write data, expected data,
// expected hit, expected memory write-backs
0 123 00000000 a5a50123 0 0
0 123 00000000 a5a50123 1 0
1 123 deadbeef deadbeef 1 0
0 123 00000000 deadbeef 1 0
1 045 11112222 11112222 0 0
0 045 00000000 11112222 1 0
// fill all four ways of set 3, way 0 dirty
1 013 cafe0013 cafe0013 0 0
0 023 00000000 a5a50023 0 0
0 033 00000000 a5a50033 0 0
0 043 00000000 a5a50043 0 0
// full set, pointer at way 0 evicts the dirty 013
0 053 00000000 a5a50053 0 1
// 013 comes back from memory, replaces way 1
0 013 00000000 cafe0013 0 0
0 023 00000000 a5a50023 0 0
0 053 00000000 a5a50053 1 0
// dirty way 3, then a write miss evicts it
1 043 43430043 43430043 1 0
1 063 60606060 60606060 0 1
0 063 00000000 60606060 1 0
0 043 00000000 43430043 0 0
f 000 00000000 00000000 0 0

// File: sim/tb_llc_core.sv
/* testbench top for the cache core, clock, reset, table-driven
   requests from the hex data file and response checks */

`timescale 1ns/10ps

module tb_llc_core;

    localparam int FIELDS         = 6;
    localparam int MAX_ENTRIES    = 64;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int HIT_LATENCY    = 4;

    // operation codes of the data file
    localparam logic [31:0] OP_READ  = 32'h0;
    localparam logic [31:0] OP_WRITE = 32'h1;
    localparam logic [31:0] OP_END   = 32'hf;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    logic                    req_write;
    llc_cfg_pkg::line_addr_t req_addr;
    llc_cfg_pkg::line_t      req_data;
    logic                    rsp_valid;
    llc_cfg_pkg::line_t      rsp_data;
    logic                    rsp_hit;
    logic                    mem_req_valid;
    logic                    mem_req_write;
    llc_cfg_pkg::line_addr_t mem_req_addr;
    llc_cfg_pkg::line_t      mem_req_data;
    logic                    mem_rsp_valid;
    llc_cfg_pkg::line_t      mem_rsp_data;
    logic                    wb_err;

    logic [31:0] testdata [MAX_ENTRIES * FIELDS];
    int          rd_strobes;
    int          wr_strobes;
    int          entry;

    // expected cache contents, tags, valid and dirty per way, evict pointers
    llc_cfg_pkg::tag_t ref_tag   [llc_cfg_pkg::LLC_SETS][llc_cfg_pkg::LLC_WAYS];
    logic              ref_vld   [llc_cfg_pkg::LLC_SETS][llc_cfg_pkg::LLC_WAYS];
    logic              ref_dirty [llc_cfg_pkg::LLC_SETS][llc_cfg_pkg::LLC_WAYS];
    int                ref_ptr   [llc_cfg_pkg::LLC_SETS];

    always #50 clk = ~clk;

    llc_core u_dut (
        .clk, .rst,
        .req_valid_i(req_valid), .req_write_i(req_write),
        .req_addr_i(req_addr), .req_data_i(req_data),
        .rsp_valid_o(rsp_valid), .rsp_data_o(rsp_data), .rsp_hit_o(rsp_hit),
        .mem_req_valid_o(mem_req_valid), .mem_req_write_o(mem_req_write),
        .mem_req_addr_o(mem_req_addr), .mem_req_data_o(mem_req_data),
        .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_data_i(mem_rsp_data)
    );

    llc_mem_model u_mem (
        .clk, .rst,
        .req_valid_i(req_valid), .req_write_i(req_write),
        .req_addr_i(req_addr), .req_data_i(req_data),
        .mem_req_valid_i(mem_req_valid), .mem_req_write_i(mem_req_write),
        .mem_req_addr_i(mem_req_addr), .mem_req_data_i(mem_req_data),
        .mem_rsp_valid_o(mem_rsp_valid), .mem_rsp_data_o(mem_rsp_data),
        .wb_err_o(wb_err)
    );

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // write-backs a request must cause, the expected set follows the request
    task automatic predict_writebacks(input logic wr, input llc_cfg_pkg::line_addr_t a,
                                      output int wb);
        int s_idx;
        int t_val;
        int way;

        way   = -1;
        wb    = 0;
        s_idx = a % llc_cfg_pkg::LLC_SETS;
        t_val = a / llc_cfg_pkg::LLC_SETS;
        for (int w = 0; w < llc_cfg_pkg::LLC_WAYS; w++) begin
            if (ref_vld[s_idx][w] && ref_tag[s_idx][w] == t_val) begin
                way = w;
            end
        end
        if (way >= 0) begin
            ref_dirty[s_idx][way] = ref_dirty[s_idx][way] | wr;
        end else begin
            // lowest free way, else the round-robin pointer
            for (int w = llc_cfg_pkg::LLC_WAYS - 1; w >= 0; w--) begin
                if (!ref_vld[s_idx][w]) begin
                    way = w;
                end
            end
            if (way < 0) begin
                way          = ref_ptr[s_idx];
                wb           = ref_dirty[s_idx][way];
                ref_ptr[s_idx] = (ref_ptr[s_idx] + 1) % llc_cfg_pkg::LLC_WAYS;
            end
            ref_vld[s_idx][way]   = 1'b1;
            ref_tag[s_idx][way]   = llc_cfg_pkg::tag_t'(t_val);
            ref_dirty[s_idx][way] = wr;
        end
    endtask

    // memory strobes per request, sampled away from the clock edge
    always @(negedge clk) begin
        if (rst && mem_req_valid) begin
            if (mem_req_write) begin
                wr_strobes++;
            end else begin
                rd_strobes++;
            end
        end
    end

    // write-back errors flagged by the memory model
    always @(negedge clk) begin
        assert (wb_err !== 1'b1) else abort_run();
    end

    task automatic run_entry(input int idx);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        logic [31:0] exp_hit;
        int          exp_wb;
        int          exp_rd;
        int          cycles;
        logic        done;

        op       = testdata[idx*FIELDS];
        addr     = testdata[idx*FIELDS+1];
        wdata    = testdata[idx*FIELDS+2];
        exp_data = testdata[idx*FIELDS+3];
        exp_hit  = testdata[idx*FIELDS+4];
        predict_writebacks(op == OP_WRITE, addr[llc_cfg_pkg::ADDR_BITS-1:0], exp_wb);

        @(posedge clk);
        rd_strobes = 0;
        wr_strobes = 0;
        req_valid <= 1'b1;
        req_write <= (op == OP_WRITE);
        req_addr  <= addr[llc_cfg_pkg::ADDR_BITS-1:0];
        req_data  <= wdata;
        // request edge, the strobe lasts one cycle
        @(posedge clk);
        req_valid <= 1'b0;

        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (rsp_valid) begin
                done = 1'b1;
            end else begin
                cycles++;
            end
        end
        assert (done) else begin
            $display("no response strobe within %0d cycles for entry %0d",
                     TIMEOUT_CYCLES, idx);
            abort_run();
        end

        compare_word("rsp_data_o", rsp_data, exp_data);
        compare_word("rsp_hit_o", {31'b0, rsp_hit}, exp_hit);
        if (exp_hit[0]) begin
            compare_word("rsp_valid_o latency", cycles, HIT_LATENCY);
        end

        // only a read miss fetches from memory
        exp_rd = (op == OP_READ && !exp_hit[0]) ? 1 : 0;
        compare_word("mem_req_valid_o read count", rd_strobes, exp_rd);
        compare_word("mem_req_valid_o write count", wr_strobes, exp_wb);

        @(negedge clk);
        compare_word("rsp_valid_o after strobe", {31'b0, rsp_valid}, 32'h0);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        entry     = 0;

        for (int s = 0; s < llc_cfg_pkg::LLC_SETS; s++) begin
            ref_ptr[s] = 0;
            for (int w = 0; w < llc_cfg_pkg::LLC_WAYS; w++) begin
                ref_vld[s][w]   = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end

        $readmemh("sim/llc_testdata.hex", testdata);
        assert (testdata[0] !== 32'hx) else begin
            $display("test data file could not be read");
            abort_run();
        end

        repeat (5) @(posedge clk);
        rst <= 1'b1;

        @(negedge clk);
        compare_word("rsp_valid_o after reset", {31'b0, rsp_valid}, 32'h0);
        compare_word("mem_req_valid_o after reset", {31'b0, mem_req_valid}, 32'h0);

        while (entry < MAX_ENTRIES && testdata[entry*FIELDS] !== OP_END) begin
            run_entry(entry);
            entry++;
        end

        repeat (2) @(posedge clk);
        if (wb_err === 1'b1) begin
            abort_run();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule
